/* all.f */
rtl/soc_pkg.sv
rtl/sram_bank.sv
rtl/gpio_regs.sv
rtl/obi_router.sv
rtl/soc_domain.sv
bench/soc_domain_sva.sv
bench/soc_domain_tb.sv

/* bench/soc_domain_sva.sv */
module soc_domain_sva (
  input logic              clk_i,
  input logic              reset_i,
  input soc_pkg::obi_req_t mgr_req_i,
  input soc_pkg::obi_rsp_t mgr_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic accept;

  assign accept = mgr_req_i.req & mgr_rsp_o.gnt;

  // Every accepted request is answered in the next cycle
  rsp_after_accept: assert property (
    @(posedge clk_i) disable iff (reset_i) accept |=> mgr_rsp_o.rvalid
  ) else $error("rvalid missing one cycle after an accepted request");

  no_rsp_without_accept: assert property (
    @(posedge clk_i) disable iff (reset_i) !accept |=> !mgr_rsp_o.rvalid
  ) else $error("rvalid seen without an accepted request in the cycle before");

  // Quiet during reset and in the cycle after it
  quiet_after_reset: assert property (
    @(posedge clk_i) $past(reset_i) |-> !mgr_rsp_o.rvalid
  ) else $error("rvalid seen during reset or right after it");

endmodule

bind soc_domain soc_domain_sva i_sva (
  .clk_i     ( clk_i     ),
  .reset_i   ( reset_i   ),
  .mgr_req_i ( mgr_req_i ),
  .mgr_rsp_o ( mgr_rsp_o )
);

/* bench/soc_domain_tb.sv */
module soc_domain_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Tests take a few hundred cycles at most
  localparam int unsigned CycleLimit = 2000;
  localparam int unsigned NumRandom = 40;

  logic clk_i;
  logic reset_i;
  soc_pkg::obi_req_t mgr_req_i;
  soc_pkg::obi_rsp_t mgr_rsp_o;
  soc_pkg::gpio_t gpio_i;
  soc_pkg::gpio_t gpio_o;
  soc_pkg::gpio_t gpio_out_en_o;
  soc_pkg::gpio_t gpio_in_sync_o;

  logic [31:0] rng_state;
  int unsigned cycle_count;
  soc_pkg::data_t sram_model [soc_pkg::SramNumWords];
  logic [soc_pkg::SramWordAddrWidth-1:0] first_idx;

  soc_domain uut (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .mgr_req_i      ( mgr_req_i      ),
    .mgr_rsp_o      ( mgr_rsp_o      ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o )
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("The run timed out after %0d cycles", CycleLimit);
      $display("Checks failed");
      $fatal(1, "Timeout");
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic soc_pkg::addr_t sram_addr(input logic [7:0] idx);
    return soc_pkg::SramBase + soc_pkg::addr_t'({idx, 2'b00});
  endfunction

  task automatic check_data(input string name, input soc_pkg::data_t exp,
                            input soc_pkg::data_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Data mismatch in %s", name);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected err %b, actual err %b", name, exp, act);
      $display("Checks failed");
      $fatal(1, "Error flag mismatch in %s", name);
    end
  endtask

  task automatic check_gpio(input string name, input soc_pkg::gpio_t exp,
                            input soc_pkg::gpio_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "GPIO mismatch in %s", name);
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus driver
  // ----------------------------------------------------------------------
  // Called at a falling edge, returns at the falling edge holding the response
  task automatic issue_request(input logic we, input soc_pkg::be_t be,
                               input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                               output soc_pkg::data_t rdata, output logic err);
    mgr_req_i = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(posedge clk_i);
    while (!mgr_rsp_o.gnt) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    mgr_req_i.req = 1'b0;
    if (!mgr_rsp_o.rvalid) begin
      $display("No response one cycle after the grant for address %h", addr);
      $display("Checks failed");
      $fatal(1, "Missing rvalid");
    end
    rdata = mgr_rsp_o.rdata;
    err = mgr_rsp_o.err;
  endtask

  task automatic bus_write(input string name, input soc_pkg::be_t be,
                           input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
                           input logic exp_err);
    soc_pkg::data_t rdata;
    logic err;
    issue_request(1'b1, be, addr, wdata, rdata, err);
    check_err(name, exp_err, err);
    if (!exp_err) begin
      check_data(name, '0, rdata);
    end
  endtask

  task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata,
                          output logic err);
    issue_request(1'b0, 4'hF, addr, '0, rdata, err);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_state();
    soc_pkg::data_t rdata;
    logic err;
    check_gpio("reset_state", '0, gpio_o);
    check_gpio("reset_state", '0, gpio_out_en_o);
    bus_read(soc_pkg::GpioBase + soc_pkg::GpioDirOffset, rdata, err);
    check_data("reset_state", '0, rdata);
    check_err("reset_state", 1'b0, err);
    bus_read(soc_pkg::GpioBase + soc_pkg::GpioOutOffset, rdata, err);
    check_data("reset_state", '0, rdata);
    check_err("reset_state", 1'b0, err);
  endtask

  task automatic test_sram_byte_enables();
    logic [7:0] idx;
    int unsigned b;
    soc_pkg::data_t full;
    soc_pkg::data_t patch;
    soc_pkg::data_t rdata;
    logic err;
    idx = 8'(next_random());
    full = next_random();
    patch = next_random();
    b = next_random() % 4;
    // Enabled lane always changes, other lanes carry unrelated data
    patch[8*b +: 8] = ~full[8*b +: 8];
    bus_write("sram_byte_enables", 4'hF, sram_addr(idx), full, 1'b0);
    sram_model[idx] = full;
    bus_write("sram_byte_enables", soc_pkg::be_t'(1 << b), sram_addr(idx),
              patch, 1'b0);
    sram_model[idx][8*b +: 8] = patch[8*b +: 8];
    bus_read(sram_addr(idx), rdata, err);
    check_data("sram_byte_enables", sram_model[idx], rdata);
    check_err("sram_byte_enables", 1'b0, err);
  endtask

  task automatic test_sram_random();
    logic [7:0] idx_list [NumRandom];
    soc_pkg::data_t wdata;
    soc_pkg::data_t rdata;
    logic err;
    // Writes and reads both run back to back
    for (int i = 0; i < NumRandom; i++) begin
      idx_list[i] = 8'(next_random());
      wdata = next_random();
      bus_write("sram_random", 4'hF, sram_addr(idx_list[i]), wdata, 1'b0);
      sram_model[idx_list[i]] = wdata;
    end
    for (int i = 0; i < NumRandom; i++) begin
      bus_read(sram_addr(idx_list[i]), rdata, err);
      check_data("sram_random", sram_model[idx_list[i]], rdata);
      check_err("sram_random", 1'b0, err);
    end
    first_idx = idx_list[0];
  endtask

  task automatic test_gpio_output();
    soc_pkg::gpio_t dir;
    soc_pkg::gpio_t out;
    soc_pkg::data_t rdata;
    logic err;
    dir = soc_pkg::gpio_t'(next_random());
    out = soc_pkg::gpio_t'(next_random());
    // Upper half carries junk that the registers drop
    bus_write("gpio_output", 4'hF, soc_pkg::GpioBase + soc_pkg::GpioDirOffset,
              {16'hA5A5, dir}, 1'b0);
    bus_write("gpio_output", 4'hF, soc_pkg::GpioBase + soc_pkg::GpioOutOffset,
              {16'h5A5A, out}, 1'b0);
    check_gpio("gpio_output", dir, gpio_out_en_o);
    check_gpio("gpio_output", out, gpio_o);
    bus_read(soc_pkg::GpioBase + soc_pkg::GpioDirOffset, rdata, err);
    check_data("gpio_output", {16'h0, dir}, rdata);
    check_err("gpio_output", 1'b0, err);
    bus_read(soc_pkg::GpioBase + soc_pkg::GpioOutOffset, rdata, err);
    check_data("gpio_output", {16'h0, out}, rdata);
    check_err("gpio_output", 1'b0, err);
  endtask

  task automatic test_gpio_input();
    soc_pkg::gpio_t pins;
    soc_pkg::data_t rdata;
    logic err;
    pins = soc_pkg::gpio_t'(next_random());
    gpio_i = pins;
    repeat (3) @(negedge clk_i);
    check_gpio("gpio_input", pins, gpio_in_sync_o);
    bus_read(soc_pkg::GpioBase + soc_pkg::GpioInOffset, rdata, err);
    check_data("gpio_input", {16'h0, pins}, rdata);
    check_err("gpio_input", 1'b0, err);
  endtask

  task automatic test_unmapped();
    soc_pkg::addr_t addr;
    soc_pkg::data_t rdata;
    logic err;
    addr = 32'h0400_0000 | (next_random() & 32'hFFC);
    bus_read(addr, rdata, err);
    check_err("unmapped", 1'b1, err);
    check_data("unmapped", soc_pkg::ErrRspData, rdata);
    bus_write("unmapped", 4'hF, addr, next_random(), 1'b1);
    bus_read(sram_addr(first_idx), rdata, err);
    check_data("unmapped", sram_model[first_idx], rdata);
    check_err("unmapped", 1'b0, err);
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    mgr_req_i = '0;
    gpio_i = '0;
    rng_state = 32'd27;
    cycle_count = 0;
    first_idx = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    test_reset_state();
    test_sram_byte_enables();
    test_sram_random();
    test_gpio_output();
    test_gpio_input();
    test_unmapped();
    $display("All checks passed");
    $finish;
  end

endmodule

/* rtl/gpio_regs.sv */
module gpio_regs (
  input  logic              clk_i,
  input  logic              reset_i,
  input  soc_pkg::obi_req_t req_i,
  output soc_pkg::obi_rsp_t rsp_o,
  input  soc_pkg::gpio_t    gpio_i,
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::gpio_t    gpio_out_en_o,
  output soc_pkg::gpio_t    gpio_in_sync_o
);

  soc_pkg::addr_t offset;
  logic wr_dir;
  logic wr_out;

  soc_pkg::gpio_t dir_q;
  soc_pkg::gpio_t out_q;
  soc_pkg::gpio_t in_meta_q;
  soc_pkg::gpio_t in_sync_q;

  logic rvalid_q;
  soc_pkg::data_t rdata_q;
  soc_pkg::data_t rdata_d;

  assign offset = req_i.addr - soc_pkg::GpioBase;
  assign wr_dir = req_i.req & req_i.we & (offset == soc_pkg::GpioDirOffset);
  assign wr_out = req_i.req & req_i.we & (offset == soc_pkg::GpioOutOffset);

  // ----------------------------------------------------------------------
  // Control registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dir_q <= '0;
      out_q <= '0;
    end else begin
      // One byte enable per byte of pins
      for (int b = 0; b < soc_pkg::GpioCount / 8; b++) begin
        if (wr_dir && req_i.be[b]) begin
          dir_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
        if (wr_out && req_i.be[b]) begin
          out_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  // ----------------------------------------------------------------------
  // Read path
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      case (offset)
        soc_pkg::GpioDirOffset: rdata_d = soc_pkg::data_t'(dir_q);
        soc_pkg::GpioOutOffset: rdata_d = soc_pkg::data_t'(out_q);
        soc_pkg::GpioInOffset:  rdata_d = soc_pkg::data_t'(in_sync_q);
        default:                rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.gnt = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err = 1'b0;

  assign gpio_o = out_q;
  assign gpio_out_en_o = dir_q;
  assign gpio_in_sync_o = in_sync_q;

endmodule

/* rtl/obi_router.sv */
module obi_router (
  input  logic              clk_i,
  input  logic              reset_i,
  input  soc_pkg::obi_req_t mgr_req_i,
  output soc_pkg::obi_rsp_t mgr_rsp_o,
  output soc_pkg::obi_req_t sram_req_o,
  input  soc_pkg::obi_rsp_t sram_rsp_i,
  output soc_pkg::obi_req_t gpio_req_o,
  input  soc_pkg::obi_rsp_t gpio_rsp_i
);

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  soc_pkg::addr_t sram_offset;
  soc_pkg::addr_t gpio_offset;
  logic sel_sram;
  logic sel_gpio;
  logic sel_err;
  logic req_en;
  logic mgr_gnt;
  logic accept;

  // Registered target of the request in flight
  logic rsp_sram_q;
  logic rsp_gpio_q;
  logic err_rvalid_q;

  // No requests leave the router while in reset
  assign req_en = mgr_req_i.req & ~reset_i;

  // Offsets wrap below the base, so one compare covers each window
  assign sram_offset = mgr_req_i.addr - soc_pkg::SramBase;
  assign gpio_offset = mgr_req_i.addr - soc_pkg::GpioBase;
  assign sel_sram = sram_offset < (soc_pkg::SramNumWords << 2);
  assign sel_gpio = gpio_offset < soc_pkg::GpioSize;
  assign sel_err = ~sel_sram & ~sel_gpio;

  // ----------------------------------------------------------------------
  // Request fan-out
  // ----------------------------------------------------------------------
  always_comb begin
    sram_req_o = mgr_req_i;
    gpio_req_o = mgr_req_i;
    sram_req_o.req = req_en & sel_sram;
    gpio_req_o.req = req_en & sel_gpio;
  end

  // Grant follows the target picked this cycle
  always_comb begin
    if (sel_sram) begin
      mgr_gnt = sram_rsp_i.gnt;
    end else if (sel_gpio) begin
      mgr_gnt = gpio_rsp_i.gnt;
    end else begin
      // Error responder always takes the request
      mgr_gnt = req_en;
    end
  end

  assign accept = req_en & mgr_gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_sram_q <= 1'b0;
      rsp_gpio_q <= 1'b0;
      err_rvalid_q <= 1'b0;
    end else begin
      err_rvalid_q <= accept & sel_err;
      if (accept) begin
        rsp_sram_q <= sel_sram;
        rsp_gpio_q <= sel_gpio;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------------------
  always_comb begin
    mgr_rsp_o.gnt = mgr_gnt;
    if (rsp_sram_q) begin
      mgr_rsp_o.rvalid = sram_rsp_i.rvalid;
      mgr_rsp_o.rdata = sram_rsp_i.rdata;
      mgr_rsp_o.err = sram_rsp_i.err;
    end else if (rsp_gpio_q) begin
      mgr_rsp_o.rvalid = gpio_rsp_i.rvalid;
      mgr_rsp_o.rdata = gpio_rsp_i.rdata;
      mgr_rsp_o.err = gpio_rsp_i.err;
    end else begin
      mgr_rsp_o.rvalid = err_rvalid_q;
      mgr_rsp_o.rdata = soc_pkg::ErrRspData;
      mgr_rsp_o.err = err_rvalid_q;
    end
  end

endmodule

/* rtl/soc_domain.sv */
module soc_domain (
  input  logic              clk_i,
  input  logic              reset_i,
  input  soc_pkg::obi_req_t mgr_req_i,
  output soc_pkg::obi_rsp_t mgr_rsp_o,
  input  soc_pkg::gpio_t    gpio_i,
  output soc_pkg::gpio_t    gpio_o,
  output soc_pkg::gpio_t    gpio_out_en_o,
  output soc_pkg::gpio_t    gpio_in_sync_o
);

  // ----------------------------------------------------------------------
  // Subordinate buses
  // ----------------------------------------------------------------------
  soc_pkg::obi_req_t sram_req;
  soc_pkg::obi_rsp_t sram_rsp;
  soc_pkg::obi_req_t gpio_req;
  soc_pkg::obi_rsp_t gpio_rsp;

  // Decode, fan-out and error responder
  obi_router i_router (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .mgr_req_i  ( mgr_req_i ),
    .mgr_rsp_o  ( mgr_rsp_o ),
    .sram_req_o ( sram_req  ),
    .sram_rsp_i ( sram_rsp  ),
    .gpio_req_o ( gpio_req  ),
    .gpio_rsp_i ( gpio_rsp  )
  );

  sram_bank i_sram (
    .clk_i ( clk_i    ),
    .req_i ( sram_req ),
    .rsp_o ( sram_rsp )
  );

  gpio_regs i_gpio (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .req_i          ( gpio_req       ),
    .rsp_o          ( gpio_rsp       ),
    .gpio_i         ( gpio_i         ),
    .gpio_o         ( gpio_o         ),
    .gpio_out_en_o  ( gpio_out_en_o  ),
    .gpio_in_sync_o ( gpio_in_sync_o )
  );

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int unsigned GpioCount = 16;
  localparam int unsigned SramNumWords = 256;
  localparam int unsigned SramWordAddrWidth = 8;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] be_t;
  typedef logic [GpioCount-1:0] gpio_t;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam addr_t SramBase = 32'h1000_0000;

  localparam addr_t GpioBase = 32'h0300_5000;
  localparam addr_t GpioDirOffset = 32'h0;
  localparam addr_t GpioOutOffset = 32'h4;
  localparam addr_t GpioInOffset = 32'h8;
  localparam addr_t GpioSize = 32'd16;

  // Returned by the error responder on unmapped accesses
  localparam data_t ErrRspData = 32'hBADC_AB1E;

  // ----------------------------------------------------------------------
  // Bus channels
  // ----------------------------------------------------------------------
  // Manager to subordinate
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } obi_rsp_t;

endpackage

/* rtl/sram_bank.sv */
module sram_bank (
  input  logic              clk_i,
  input  soc_pkg::obi_req_t req_i,
  output soc_pkg::obi_rsp_t rsp_o
);

  soc_pkg::data_t mem [soc_pkg::SramNumWords];

  soc_pkg::addr_t byte_offset;
  logic [soc_pkg::SramWordAddrWidth-1:0] word_addr;

  // Response side
  logic rvalid_q;
  soc_pkg::data_t rdata_q;

  // Byte address inside the bank, low two bits dropped
  assign byte_offset = req_i.addr - soc_pkg::SramBase;
  assign word_addr = byte_offset[soc_pkg::SramWordAddrWidth+1:2];

  // ----------------------------------------------------------------------
  // Memory array
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data one cycle after the grant, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem[word_addr];
    end
  end

  // Cleared by the router holding req low in reset
  always_ff @(posedge clk_i) begin
    rvalid_q <= req_i.req;
  end

  assign rsp_o.gnt = req_i.req;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err = 1'b0;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module soc_domain_tb -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vsoc_domain_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "PASS"
exit 0
